// ==== common/srcPkg.sv ====
package srcPkg;

    localparam int wordW = 32;                  // bus and register width
    localparam int regCount = 16;               // general registers r0..r15
    localparam int regIdxW = $clog2(regCount);  // G field width
    localparam int memAddrW = 9;                // 512 memory words
    localparam int constW = 19;                 // immediate field width

    // Mini SRC opcode encodings
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opMul  = 5'b01111,
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opMfhi = 5'b11000,
        opMflo = 5'b11001,
        opHalt = 5'b11011
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd  = 3'd0,  // zero so an idle control word adds
        aluSub  = 3'd1,
        aluAnd  = 3'd2,
        aluOr   = 3'd3,
        aluMul  = 3'd4,
        aluInc4 = 3'd5   // pc increment
    } aluOpT;

    typedef struct packed {
        logic [4:0]                       opcode;
        logic [regIdxW-1:0]               ra;
        logic [regIdxW-1:0]               rb;
        logic [regIdxW-1:0]               rc;
        logic [wordW-5-3*regIdxW-1:0]     pad;     // unused low bits
    } rFormT;

    typedef struct packed {
        logic [4:0]         opcode;
        logic [regIdxW-1:0] ra;
        logic [regIdxW-1:0] rb;
        logic [constW-1:0]  c;       // sign extended on the bus
    } iFormT;

    // one instruction word, two decodings
    typedef union packed {
        rFormT rForm;
        iFormT iForm;
    } instrU;

    typedef struct packed {
        logic  gra;
        logic  grb;
        logic  grc;
        logic  rout;
        logic  baOut;      // rb as base, r0 reads zero
        logic  pcOut;
        logic  hiOut;
        logic  loOut;
        logic  zHighOut;
        logic  zLowOut;
        logic  mdrOut;
        logic  cOut;
        logic  inPortOut;
        logic  rin;
        logic  pcIn;
        logic  irIn;
        logic  yIn;
        logic  zIn;
        logic  hiIn;       // loads from z high
        logic  loIn;       // loads from z low
        logic  marIn;
        logic  mdrIn;
        logic  outPortIn;
        logic  memRead;
        logic  memWrite;
        aluOpT aluOp;
    } ctrlWordT;

    typedef struct packed {
        logic [memAddrW-1:0] addr;   // word address
        logic [wordW-1:0]    wdata;
        logic                write;
    } memReqT;

endpackage

// ==== datapath/regFile.sv ====
`timescale 1ns/1ps

module regFile
    import srcPkg::*;
(
    input  logic             clock,
    input  logic             rst,
    input  instrU            ir,
    input  logic             gra,
    input  logic             grb,
    input  logic             grc,
    input  logic             rin,
    input  logic             rout,
    input  logic             baOut,
    input  logic [wordW-1:0] busIn,
    output logic [wordW-1:0] busOut
);

    logic [wordW-1:0]   regs [regCount];
    logic [regIdxW-1:0] sel;   // index picked by the G signals

    always_comb begin
        sel = '0;
        if (gra) begin
            sel = ir.rForm.ra;
        end else if (grb) begin
            sel = ir.rForm.rb;
        end else if (grc) begin
            sel = ir.rForm.rc;
        end
    end

    always_comb begin
        busOut = '0;
        if (baOut && sel == '0) begin
            busOut = '0;   // base address mode, r0 is zero
        end else if (rout || baOut) begin
            busOut = regs[sel];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rin) begin
            regs[sel] <= busIn;
        end
    end

endmodule

// ==== datapath/srcAlu.sv ====
`timescale 1ns/1ps

module srcAlu
    import srcPkg::*;
(
    input  aluOpT              aluOp,
    input  logic [wordW-1:0]   a,        // y register
    input  logic [wordW-1:0]   b,        // bus
    output logic [2*wordW-1:0] result    // into z
);

    logic signed [2*wordW-1:0] product;
    logic [wordW-1:0]          sum;
    logic [wordW-1:0]          diff;

    // operands widen signed before the multiply
    assign product = $signed(a) * $signed(b);
    assign sum = a + b;
    assign diff = a - b;

    always_comb begin
        result = '0;
        case (aluOp)
            aluAdd: begin
                result = {{wordW{1'b0}}, sum};    // wraps mod 2^32
            end
            aluSub: begin
                result = {{wordW{1'b0}}, diff};
            end
            aluAnd: begin
                result = {{wordW{1'b0}}, a & b};
            end
            aluOr: begin
                result = {{wordW{1'b0}}, a | b};
            end
            aluMul: begin
                result = product;                 // hi half for HI, lo half for LO
            end
            aluInc4: begin
                result = {{wordW{1'b0}}, b + wordW'(4)};   // next pc
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== datapath/srcDatapath.sv ====
`timescale 1ns/1ps

module srcDatapath
    import srcPkg::*;
(
    input  logic                clock,
    input  logic                rst,
    input  ctrlWordT            ctrl,
    input  logic [wordW-1:0]    inPort,
    output logic [wordW-1:0]    outPort,
    output instrU               ir,
    output logic [memAddrW-1:0] marOut,
    output logic [wordW-1:0]    mdrOut,
    input  logic [wordW-1:0]    rdata,
    input  logic                mdrLoad
);

    logic [wordW-1:0]    bus;
    logic [wordW-1:0]    pc;
    logic [wordW-1:0]    y;         // first alu operand
    logic [2*wordW-1:0]  z;
    logic [wordW-1:0]    hi;
    logic [wordW-1:0]    lo;
    logic [memAddrW-1:0] mar;       // word address
    logic [wordW-1:0]    mdr;
    logic [wordW-1:0]    inReg;     // sampled input port
    logic [wordW-1:0]    cSext;
    logic [wordW-1:0]    rfBus;
    logic [2*wordW-1:0]  aluResult;

    assign cSext = {{(wordW-constW){ir.iForm.c[constW-1]}}, ir.iForm.c};
    assign marOut = mar;
    assign mdrOut = mdr;

    regFile i_regFile (
        .clock  (clock),
        .rst    (rst),
        .ir     (ir),
        .gra    (ctrl.gra),
        .grb    (ctrl.grb),
        .grc    (ctrl.grc),
        .rin    (ctrl.rin),
        .rout   (ctrl.rout),
        .baOut  (ctrl.baOut),
        .busIn  (bus),
        .busOut (rfBus)
    );

    srcAlu i_alu (
        .aluOp  (ctrl.aluOp),
        .a      (y),
        .b      (bus),
        .result (aluResult)
    );

    // one source drives the bus per step
    always_comb begin
        bus = '0;
        if (ctrl.rout || ctrl.baOut) begin
            bus = rfBus;
        end else if (ctrl.pcOut) begin
            bus = pc;
        end else if (ctrl.hiOut) begin
            bus = hi;
        end else if (ctrl.loOut) begin
            bus = lo;
        end else if (ctrl.zLowOut) begin
            bus = z[wordW-1:0];
        end else if (ctrl.mdrOut) begin
            bus = mdr;
        end else if (ctrl.cOut) begin
            bus = cSext;
        end else if (ctrl.inPortOut) begin
            bus = inReg;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;   // fetch starts at address 0
        end else if (ctrl.pcIn) begin
            pc <= bus;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.irIn) ir <= bus;
        if (ctrl.yIn) y <= bus;
        if (ctrl.zIn) z <= aluResult;
        if (ctrl.hiIn) hi <= z[2*wordW-1:wordW];   // straight from z
        if (ctrl.loIn) lo <= z[wordW-1:0];
        if (ctrl.marIn) mar <= bus[memAddrW+1:2];  // byte address to word
        if (mdrLoad) begin
            mdr <= rdata;    // memory read data wins
        end else if (ctrl.mdrIn) begin
            mdr <= bus;
        end
        if (ctrl.outPortIn) outPort <= bus;
        inReg <= inPort;
    end

endmodule

// ==== dv/miniSrcTb.sv ====
`timescale 1ns/1ps

module miniSrcTb
    import srcPkg::*;
();

    localparam int instrBudget = 30;      // program holds 25 instructions
    localparam int cyclesPerInstr = 40;   // ld with two slow accesses stays below this
    localparam int maxCycles = instrBudget * cyclesPerInstr;
    localparam int dataWord = 200;        // A at byte 800, B at byte 804
    localparam int sumWord = 205;         // store target, 320 + 500 bytes

    logic             clock;
    logic             rst;
    logic [wordW-1:0] inPort;
    logic [wordW-1:0] outPort;
    logic             outStrobe;
    logic             halted;
    logic             req;
    memReqT           memReq;
    logic             ack;
    logic [wordW-1:0] rdata;

    logic [31:0] lfsr;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] inVal;
    logic [31:0] expected [$];   // outPort values in program order
    int          cycles;
    logic        prevRst;
    logic        prevReq;
    logic        prevAck;
    memReqT      prevMemReq;

    miniSrc i_dut (
        .clock     (clock),
        .rst       (rst),
        .inPort    (inPort),
        .outPort   (outPort),
        .outStrobe (outStrobe),
        .halted    (halted),
        .req       (req),
        .memReq    (memReq),
        .ack       (ack),
        .rdata     (rdata)
    );

    tbMemory i_mem (
        .clock  (clock),
        .req    (req),
        .memReq (memReq),
        .ack    (ack),
        .rdata  (rdata)
    );

    function automatic logic [31:0] lfsrBits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);   // galois taps
        end
        return bits;
    endfunction

    // opcode 31:27, ra 26:23, rb 22:19, rc 18:15
    function automatic logic [31:0] rInstr(opcodeT op, int ra, int rb, int rc);
        return {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
    endfunction

    function automatic logic [31:0] iInstr(opcodeT op, int ra, int rb, int c);
        return {op, ra[3:0], rb[3:0], c[18:0]};   // 19-bit constant
    endfunction

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on a failed check");
    endtask

    task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on a wrong value");
    endtask

    task automatic loadProgram();
        logic [31:0] prog [$];
        for (int i = 0; i < 2**memAddrW; i++) begin
            i_mem.mem[i] = 32'hc0de0000 + i;   // every word differs
        end
        prog.push_back(iInstr(opAddi, 0, 0, 64));      // r0 = 64, ld base must ignore it
        prog.push_back(iInstr(opLd, 1, 0, 800));       // r1 = A
        prog.push_back(iInstr(opLd, 2, 0, 804));       // r2 = B
        prog.push_back(rInstr(opAdd, 3, 1, 2));
        prog.push_back(rInstr(opOut, 3, 0, 0));
        prog.push_back(rInstr(opSub, 4, 1, 2));
        prog.push_back(rInstr(opOut, 4, 0, 0));
        prog.push_back(rInstr(opAnd, 5, 1, 2));
        prog.push_back(rInstr(opOut, 5, 0, 0));
        prog.push_back(rInstr(opOr, 6, 1, 2));
        prog.push_back(rInstr(opOut, 6, 0, 0));
        prog.push_back(iInstr(opAddi, 7, 1, -4660));   // negative constant
        prog.push_back(rInstr(opOut, 7, 0, 0));
        prog.push_back(rInstr(opMul, 0, 1, 2));        // hi:lo = A * B
        prog.push_back(rInstr(opMfhi, 8, 0, 0));
        prog.push_back(rInstr(opOut, 8, 0, 0));
        prog.push_back(rInstr(opMflo, 9, 0, 0));
        prog.push_back(rInstr(opOut, 9, 0, 0));
        prog.push_back(iInstr(opAddi, 11, 0, 256));    // r11 = 64 + 256
        prog.push_back(iInstr(opSt, 3, 11, 500));      // A+B to byte 820
        prog.push_back(iInstr(opLd, 12, 11, 500));
        prog.push_back(rInstr(opOut, 12, 0, 0));
        prog.push_back(rInstr(opIn, 13, 0, 0));
        prog.push_back(rInstr(opOut, 13, 0, 0));
        prog.push_back(rInstr(opHalt, 0, 0, 0));
        foreach (prog[i]) begin
            i_mem.mem[i] = prog[i];
        end
        i_mem.mem[dataWord] = opA;
        i_mem.mem[dataWord + 1] = opB;
    endtask

    task automatic buildExpected();
        longint      sa;
        longint      sb;
        logic [63:0] prod;
        sa = $signed(opA);   // sign extend to 64
        sb = $signed(opB);
        prod = sa * sb;
        expected.push_back(opA + opB);
        expected.push_back(opA - opB);
        expected.push_back(opA & opB);
        expected.push_back(opA | opB);
        expected.push_back(opA - 32'd4660);
        expected.push_back(prod[63:32]);
        expected.push_back(prod[31:0]);
        expected.push_back(opA + opB);   // stored, then loaded back
        expected.push_back(inVal);
    endtask

    task automatic checkOutput();
        logic [31:0] exp;
        assert (expected.size() > 0) else failRun("outStrobe with no output left to expect");
        exp = expected.pop_front();
        assert (outPort === exp) else reportMismatch("outPort", outPort, exp);
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= maxCycles) begin
            failRun($sformatf("timeout, no halt after %0d cycles", cycles));
        end
    end

    // outputs sampled mid-cycle
    always @(negedge clock) begin
        if (rst || prevRst) begin
            assert (req === 1'b0 && outStrobe === 1'b0 && halted === 1'b0)
                else failRun("req, outStrobe or halted not low around reset");
        end
        if (!rst) begin
            if (prevReq && !req) begin
                assert (prevAck) else failRun("req dropped while ack was low");
            end
            if (!prevReq && req) begin
                assert (!prevAck) else failRun("req raised while ack was still high");
            end
            if (prevReq || prevAck) begin
                assert (memReq === prevMemReq) else failRun("memReq changed during handshake");
            end
            if (outStrobe) begin
                checkOutput();
            end
        end
        prevRst = rst;
        prevReq = req;
        prevAck = ack;
        prevMemReq = memReq;
    end

    initial begin
        cycles = 0;
        lfsr = 32'hfb07ea05;
        rst = 1'b1;
        opA = lfsrBits(32);
        opB = lfsrBits(32);
        inVal = lfsrBits(32);
        inPort = inVal;   // held for the whole run
        loadProgram();
        buildExpected();
        repeat (8) @(posedge clock);
        #1;
        rst = 1'b0;
        while (halted !== 1'b1) @(negedge clock);
        assert (expected.size() == 0) else failRun("halted before every output was seen");
        assert (i_mem.mem[sumWord] === opA + opB)
            else reportMismatch("mem[205]", i_mem.mem[sumWord], opA + opB);
        repeat (50) begin
            @(negedge clock);
            assert (halted === 1'b1) else failRun("halted fell after the halt instruction");
            assert (req === 1'b0) else failRun("memory request raised after halt");
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== dv/tbMemory.sv ====
`timescale 1ns/1ps

module tbMemory
    import srcPkg::*;
(
    input  logic             clock,
    input  logic             req,
    input  memReqT           memReq,
    output logic             ack,
    output logic [wordW-1:0] rdata
);

    logic [wordW-1:0] mem [2**memAddrW];   // backdoor loaded by the testbench top
    logic [31:0]      lfsr;                // source of ack delays
    int               delay;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsrBits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);   // feedback taps
        end
        return bits;
    endfunction

    task automatic nextCycle();
        @(posedge clock);
        #1;   // act just after the edge
    endtask

    // four-phase slave, req seen then ack, req drop then ack drop
    initial begin
        lfsr = 32'hfb07ea05;
        ack = 1'b0;
        rdata = '0;
        forever begin
            nextCycle();
            if (req) begin
                delay = int'(lfsrBits(3));   // 0..7 cycles before ack
                repeat (delay) nextCycle();
                if (memReq.write) begin
                    mem[memReq.addr] = memReq.wdata;
                end else begin
                    rdata = mem[memReq.addr];   // valid together with ack
                end
                ack = 1'b1;
                while (req) nextCycle();        // master drops req once it sees ack
                delay = int'(lfsrBits(3));      // release delay
                repeat (delay) nextCycle();
                ack = 1'b0;
            end
        end
    end

endmodule

// ==== files.f ====
common/srcPkg.sv
datapath/regFile.sv
datapath/srcAlu.sv
datapath/srcDatapath.sv
hdl/memPort.sv
hdl/controlUnit.sv
hdl/miniSrc.sv
dv/tbMemory.sv
dv/miniSrcTb.sv

// ==== hdl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
    import srcPkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  instrU    ir,
    input  logic     done,
    output ctrlWordT ctrl,
    output logic     start,
    output logic     outStrobe,
    output logic     halted
);

    typedef enum logic [3:0] {
        sIdle, sT0, sT1, sT2, sT3, sT4, sT5, sT6, sT7, sMemWait, sHaltStop
    } stepT;

    stepT   step;
    stepT   retStep;   // step taken once memWait sees done
    opcodeT op;
    logic   isMem;     // ld or st

    assign op = opcodeT'(ir.rForm.opcode);   // ir is stable from T3 on
    assign isMem = (op == opLd) || (op == opSt);
    assign start = ctrl.memRead | ctrl.memWrite;   // such steps last one cycle

    always_ff @(posedge clock) begin
        if (rst) begin
            step <= sIdle;        // all control fields low during reset
            retStep <= sT2;
            outStrobe <= 1'b0;
            halted <= 1'b0;
        end else begin
            outStrobe <= ctrl.outPortIn;   // cycle after outPort loads
            case (step)
                sIdle: step <= sT0;
                sT0: step <= sT1;
                sT1: begin
                    step <= sMemWait;     // instruction fetch
                    retStep <= sT2;
                end
                sMemWait: begin
                    if (done) begin
                        step <= retStep;
                    end
                end
                sT2: step <= sT3;
                sT3: begin
                    case (op)
                        opLd, opSt, opAdd, opSub, opAnd, opOr, opAddi, opMul: step <= sT4;
                        opHalt: begin
                            step <= sHaltStop;
                            halted <= 1'b1;   // sticky until reset
                        end
                        default: step <= sT0;  // mfhi mflo in out, unknown codes act as nop
                    endcase
                end
                sT4: step <= sT5;
                sT5: step <= isMem ? sT6 : sT0;
                sT6: begin
                    if (op == opLd) begin
                        step <= sMemWait;
                        retStep <= sT7;   // then mdr to ra
                    end else begin
                        step <= sT7;
                    end
                end
                sT7: begin
                    if (op == opSt) begin
                        step <= sMemWait;
                        retStep <= sT0;
                    end else begin
                        step <= sT0;
                    end
                end
                sHaltStop: step <= sHaltStop;
                default: step <= sIdle;
            endcase
        end
    end

    always_comb begin
        ctrl = '0;   // memWait and haltStop keep every enable low
        case (step)
            sT0: begin
                ctrl.pcOut = 1'b1;
                ctrl.marIn = 1'b1;
                ctrl.aluOp = aluInc4;   // pc + 4 into z
                ctrl.zIn = 1'b1;
            end
            sT1: begin
                ctrl.zLowOut = 1'b1;
                ctrl.pcIn = 1'b1;
                ctrl.memRead = 1'b1;
            end
            sT2: begin
                ctrl.mdrOut = 1'b1;
                ctrl.irIn = 1'b1;
            end
            sT3: begin
                case (op)
                    opMfhi: begin
                        ctrl.hiOut = 1'b1;
                        ctrl.gra = 1'b1;
                        ctrl.rin = 1'b1;
                    end
                    opMflo: begin
                        ctrl.loOut = 1'b1;
                        ctrl.gra = 1'b1;
                        ctrl.rin = 1'b1;
                    end
                    opIn: begin
                        ctrl.inPortOut = 1'b1;
                        ctrl.gra = 1'b1;
                        ctrl.rin = 1'b1;
                    end
                    opOut: begin
                        ctrl.gra = 1'b1;
                        ctrl.rout = 1'b1;
                        ctrl.outPortIn = 1'b1;
                    end
                    opLd, opSt: begin
                        ctrl.grb = 1'b1;
                        ctrl.baOut = 1'b1;   // r0 base gives c alone
                        ctrl.yIn = 1'b1;
                    end
                    opAdd, opSub, opAnd, opOr, opAddi, opMul: begin
                        ctrl.grb = 1'b1;
                        ctrl.rout = 1'b1;
                        ctrl.yIn = 1'b1;
                    end
                    default: ;
                endcase
            end
            sT4: begin
                ctrl.zIn = 1'b1;
                case (op)
                    opSub: ctrl.aluOp = aluSub;
                    opAnd: ctrl.aluOp = aluAnd;
                    opOr: ctrl.aluOp = aluOr;
                    opMul: ctrl.aluOp = aluMul;
                    default: ctrl.aluOp = aluAdd;   // add addi ld st
                endcase
                if (isMem || op == opAddi) begin
                    ctrl.cOut = 1'b1;
                end else begin
                    ctrl.grc = 1'b1;
                    ctrl.rout = 1'b1;
                end
            end
            sT5: begin
                if (op == opMul) begin
                    ctrl.hiIn = 1'b1;
                    ctrl.loIn = 1'b1;
                end else if (isMem) begin
                    ctrl.zLowOut = 1'b1;
                    ctrl.marIn = 1'b1;   // effective address
                end else begin
                    ctrl.zLowOut = 1'b1;
                    ctrl.gra = 1'b1;
                    ctrl.rin = 1'b1;
                end
            end
            sT6: begin
                if (op == opLd) begin
                    ctrl.memRead = 1'b1;
                end else begin
                    ctrl.gra = 1'b1;     // store data into mdr
                    ctrl.rout = 1'b1;
                    ctrl.mdrIn = 1'b1;
                end
            end
            sT7: begin
                if (op == opSt) begin
                    ctrl.memWrite = 1'b1;
                end else begin
                    ctrl.mdrOut = 1'b1;
                    ctrl.gra = 1'b1;
                    ctrl.rin = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/memPort.sv ====
`timescale 1ns/1ps

module memPort
    import srcPkg::*;
(
    input  logic                clock,
    input  logic                rst,
    input  logic                start,
    input  logic [memAddrW-1:0] address,
    input  logic [wordW-1:0]    wdata,
    input  logic                write,
    output logic                done,
    output logic                mdrLoad,
    output logic                req,
    output memReqT              memReq,
    input  logic                ack
);

    typedef enum logic [1:0] {
        idle,
        waitAck,       // req high, slave busy
        waitRelease    // req dropped, ack still high
    } portStateT;

    portStateT state;

    assign mdrLoad = (state == waitAck) && ack && !memReq.write;   // rdata valid with ack
    assign done = (state == waitRelease) && !ack;                // handshake closed

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= idle;
            req <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        req <= 1'b1;
                        state <= waitAck;
                    end
                end
                waitAck: begin
                    if (ack) begin
                        req <= 1'b0;
                        state <= waitRelease;
                    end
                end
                waitRelease: begin
                    if (!ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // request held from start until the port is idle again
    always_ff @(posedge clock) begin
        if (state == idle && start) begin
            memReq.addr <= address;
            memReq.wdata <= wdata;
            memReq.write <= write;
        end
    end

endmodule

// ==== hdl/miniSrc.sv ====
`timescale 1ns/1ps

module miniSrc
    import srcPkg::*;
(
    input  logic             clock,
    input  logic             rst,
    input  logic [wordW-1:0] inPort,
    output logic [wordW-1:0] outPort,
    output logic             outStrobe,
    output logic             halted,
    output logic             req,
    output memReqT           memReq,
    input  logic             ack,
    input  logic [wordW-1:0] rdata
);

    ctrlWordT            ctrl;      // control word for the current step
    instrU               ir;
    logic                start;     // one cycle memory kick
    logic                done;
    logic                mdrLoad;   // read data strobe into mdr
    logic [memAddrW-1:0] marOut;
    logic [wordW-1:0]    mdrOut;

    controlUnit i_control (
        .clock     (clock),
        .rst       (rst),
        .ir        (ir),
        .done      (done),
        .ctrl      (ctrl),
        .start     (start),
        .outStrobe (outStrobe),
        .halted    (halted)
    );

    srcDatapath i_datapath (
        .clock   (clock),
        .rst     (rst),
        .ctrl    (ctrl),
        .inPort  (inPort),
        .outPort (outPort),
        .ir      (ir),
        .marOut  (marOut),
        .mdrOut  (mdrOut),
        .rdata   (rdata),
        .mdrLoad (mdrLoad)
    );

    memPort i_memPort (
        .clock   (clock),
        .rst     (rst),
        .start   (start),
        .address (marOut),
        .wdata   (mdrOut),
        .write   (ctrl.memWrite),   // high only in a store start step
        .done    (done),
        .mdrLoad (mdrLoad),
        .req     (req),
        .memReq  (memReq),
        .ack     (ack)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
# the exit status is the simulator's, a $fatal gives a nonzero status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module miniSrcTb -o miniSrcTbSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/miniSrcTbSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0
